// ==== bench/ptw_testdata.txt ====
# m word_addr pte
# t satp id vaddr flush(0 none 1 ic 2 dc 3 fence) respond(1)/cancelled(0) perm paddr
m 2001 0000000000004401
m 2202 0000000000004801
m 2403 00000000000d14c7
m 2204 00000000001000cb
m 2003 00000000100000cf
m 2406 00000000000d14c6
m 2205 00000000001004cb
m 4001 0000000000008401
m 4200 0000000000008801
m 4400 0000000000008c01
m 4602 00000000001ddcd3
m 6001 000000000000c401
m 6200 000000000000c801
m 6400 000000000000cc01
m 6600 000000000000d001
m 6801 00000000002220c7
t 8000000000000010 11 0000000040403000 0 1 c7 0000000000345000
t 8000000000000010 12 0000000040805000 0 1 cb 0000000000405000
t 8000000000000010 13 00000000c0c07000 0 1 cf 0000000040c07000
t 8000000000000010 14 0000000040406000 0 1 00 0000000000000000
t 8000000000000010 15 0000000040a00000 0 1 00 0000000000000000
t 0000000000000000 16 0000000000001000 0 1 00 0000000000000000
t 9000000000000020 21 0000008000002000 0 1 d3 0000000000777000
t a000000000000030 22 0001000000001000 0 1 c7 0000000000888000
t 8000000000000010 81 0000000040403000 1 0 00 0000000000000000
t 8000000000000010 82 0000000040403000 2 1 c7 0000000000345000
t 8000000000000010 c3 0000000040403000 3 0 00 0000000000000000
t 8000000000000010 c4 0000000040805000 0 1 cb 0000000000405000

// ==== src.f ====
+incdir+hw
hw/ptw_pkg.sv
hw/walk_config.sv
hw/request_hold.sv
hw/pte_check.sv
hw/page_walker.sv
hw/ptw_top.sv
bench/mem_model.sv
bench/ptw_tb.sv

// ==== bench/ptw_tb.sv ====
/*
 * Page table walker testbench.
 * Loads page tables and test records from the data file, runs
 * translations with flushes and fences, checks every response.
 */

module ptw_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ptw_pkg::*;

    localparam int CANCEL_WINDOW   = 60;
    localparam int CYCLES_PER_TEST = 100;
    localparam int OFFER_LIMIT     = 20;

    logic        clk;
    logic        rst;
    logic        fence_vma;
    logic        satp_we;
    pte_t        satp_wdata;
    logic        ic_flush;
    logic        dc_flush;
    xlate_req_t  req;
    xlate_resp_t resp;
    req_id_t     mem_req_id;
    paddr_t      mem_addr;
    req_id_t     mem_resp_id;
    pte_t        mem_rdata;

    pte_t    t_satp[$];
    req_id_t t_id[$];
    vaddr_t  t_va[$];
    int      t_flush[$];        // 0 none, 1 ic, 2 dc, 3 fence
    int      t_expect[$];       // 1 respond, 0 cancelled
    perm_t   t_perm[$];
    paddr_t  t_paddr[$];
    int      pass_count;
    int      fail_count;
    logic    loaded;

    ptw_top dut (
        .clk         (clk),
        .rst         (rst),
        .fence_vma   (fence_vma),
        .satp_we     (satp_we),
        .satp_wdata  (satp_wdata),
        .ic_flush    (ic_flush),
        .dc_flush    (dc_flush),
        .req         (req),
        .resp        (resp),
        .mem_req_id  (mem_req_id),
        .mem_addr    (mem_addr),
        .mem_resp_id (mem_resp_id),
        .mem_rdata   (mem_rdata)
    );

    mem_model #(.SEED(32'h820a)) u_mem (
        .clk     (clk),
        .rst     (rst),
        .req_id  (mem_req_id),
        .addr    (mem_addr),
        .resp_id (mem_resp_id),
        .rdata   (mem_rdata)
    );

    always #5 clk = ~clk;

    task automatic read_testdata();
        int          fd;
        string       line;
        logic [63:0] waddr;
        pte_t        data;
        pte_t        satp;
        req_id_t     id;
        vaddr_t      va;
        int          flush;
        int          expect_resp;
        perm_t       perm;
        paddr_t      paddr;
        fd = $fopen("bench/ptw_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "m %h %h", waddr, data) == 2) begin
                    u_mem.load_word(waddr, data);
                end else if ($sscanf(line, "t %h %h %h %d %d %h %h", satp, id, va, flush,
                                     expect_resp, perm, paddr) == 7) begin
                    t_satp.push_back(satp);
                    t_id.push_back(id);
                    t_va.push_back(va);
                    t_flush.push_back(flush);
                    t_expect.push_back(expect_resp);
                    t_perm.push_back(perm);
                    t_paddr.push_back(paddr);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_satp(input pte_t value);
        @(negedge clk);
        satp_we    = 1'b1;
        satp_wdata = value;
        @(negedge clk);
        satp_we    = 1'b0;
    endtask

    task automatic apply_flush(input int kind);
        ic_flush  = (kind == 1);
        dc_flush  = (kind == 2);
        fence_vma = (kind == 3);
    endtask

    task automatic run_test(input int i);
        logic        ok;
        logic        seen;
        int          k;
        int          waited;
        xlate_resp_t got;
        ok   = 1'b1;
        seen = 1'b0;
        got  = '0;
        write_satp(t_satp[i]);
        req.id    = t_id[i];
        req.vaddr = t_va[i];
        waited    = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (dut.held.id != t_id[i] && waited < OFFER_LIMIT);
        req = '0;
        assert (dut.held.id == t_id[i]) else begin
            $display("test %0d: request %h was never accepted", i, t_id[i]);
            ok = 1'b0;
        end
        k = 0;
        while (!seen && k < CANCEL_WINDOW) begin
            @(negedge clk);
            k++;
            apply_flush(0);                 // flush lasts one cycle
            if (mem_req_id != '0) begin
                assert (mem_req_id == t_id[i]) else begin
                    $display("** Error: mem_req_id = %h, expected %h", mem_req_id, t_id[i]);
                    ok = 1'b0;
                end
                assert (mem_addr[2:0] == 3'b000) else begin
                    $display("** Error: mem_addr = %h, expected word aligned", mem_addr);
                    ok = 1'b0;
                end
            end
            if (resp.id != '0) begin
                seen = 1'b1;
                got  = resp;
            end else if (k == 3) begin
                apply_flush(t_flush[i]);
            end
        end
        if (t_expect[i] != 0) begin
            assert (seen) else begin
                $display("test %0d: no response within %0d cycles", i, CANCEL_WINDOW);
                ok = 1'b0;
            end
            if (seen) begin
                assert (got.id == t_id[i]) else begin
                    $display("** Error: resp.id = %h, expected %h", got.id, t_id[i]);
                    ok = 1'b0;
                end
                assert (got.perm == t_perm[i]) else begin
                    $display("** Error: resp.perm = %h, expected %h", got.perm, t_perm[i]);
                    ok = 1'b0;
                end
                assert (got.paddr == t_paddr[i]) else begin
                    $display("** Error: resp.paddr = %h, expected %h", got.paddr, t_paddr[i]);
                    ok = 1'b0;
                end
            end
        end else begin
            assert (!seen) else begin
                $display("test %0d: cancelled request answered with id %h", i, got.id);
                ok = 1'b0;
            end
        end
        repeat (2) begin                    // let the hold stage settle
            @(negedge clk);
            assert (resp.id == '0) else begin
                $display("test %0d: unexpected extra response with id %h", i, resp.id);
                ok = 1'b0;
            end
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d id %h: %s", i, t_id[i], ok ? "ok" : "failed");
    endtask

    // watchdog
    initial begin
        wait (loaded);
        #(t_id.size() * CYCLES_PER_TEST * 10);
        $display("watchdog expired after %0d cycles", t_id.size() * CYCLES_PER_TEST);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        fence_vma  = 1'b0;
        satp_we    = 1'b0;
        satp_wdata = '0;
        ic_flush   = 1'b0;
        dc_flush   = 1'b0;
        req        = '0;
        pass_count = 0;
        fail_count = 0;
        loaded     = 1'b0;
        read_testdata();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < t_id.size(); i++) begin
            run_test(i);
        end
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/mem_model.sv ====
/*
 * Page table memory model.
 * Holds 64-bit words by word address and answers each walker read
 * after a random latency of 1 to 4 cycles.
 */

module mem_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic             clk,
    input  logic             rst,
    input  ptw_pkg::req_id_t req_id,
    input  ptw_pkg::paddr_t  addr,
    output ptw_pkg::req_id_t resp_id,
    output ptw_pkg::pte_t    rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import ptw_pkg::*;

    pte_t words [logic [63:0]];     // keyed by word address

    task automatic load_word(input logic [63:0] waddr, input pte_t data);
        words[waddr] = data;
    endtask

    // unloaded words carry their address and have V clear
    function automatic pte_t read_word(input paddr_t a);
        logic [63:0] waddr;
        waddr = a >> 3;
        if (words.exists(waddr)) begin
            return words[waddr];
        end
        return {waddr[62:0], 1'b0};
    endfunction

    initial begin
        int unsigned cnt;
        logic        busy;
        void'($urandom(SEED));
        resp_id = '0;
        rdata   = '0;
        busy    = 1'b0;
        cnt     = 0;
        forever begin
            @(negedge clk);
            resp_id = '0;                   // one cycle strobe
            if (rst || req_id == '0) begin
                busy = 1'b0;                // read withdrawn or done
            end else begin
                if (!busy) begin
                    busy = 1'b1;
                    cnt  = $urandom % 4 + 1;
                end
                cnt = cnt - 1;
                if (cnt == 0) begin
                    resp_id = req_id;
                    rdata   = read_word(addr);
                    busy    = 1'b0;
                end
            end
        end
    end

endmodule

// ==== hw/ptw_top.sv ====
/*
 * Page table walker top level.
 * Joins the configuration registers, the request hold stage and
 * the walker with its memory read port.
 */

module ptw_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fence_vma,
    input  logic                 satp_we,
    input  ptw_pkg::pte_t        satp_wdata,
    input  logic                 ic_flush,
    input  logic                 dc_flush,
    input  ptw_pkg::xlate_req_t  req,
    output ptw_pkg::xlate_resp_t resp,
    output ptw_pkg::req_id_t     mem_req_id,
    output ptw_pkg::paddr_t      mem_addr,
    input  ptw_pkg::req_id_t     mem_resp_id,
    input  ptw_pkg::pte_t        mem_rdata
);
    import ptw_pkg::*;

    logic [3:0] satp_mode;
    ppn_t       root_ppn;
    flush_sel_t flush_sel;      // shared by hold stage and walker
    xlate_req_t held;

    walk_config u_config (
        .clk        (clk),
        .rst        (rst),
        .satp_we    (satp_we),
        .satp_wdata (satp_wdata),
        .ic_flush   (ic_flush),
        .dc_flush   (dc_flush),
        .satp_mode  (satp_mode),
        .root_ppn   (root_ppn),
        .flush_sel  (flush_sel)
    );

    request_hold u_hold (
        .clk       (clk),
        .rst       (rst),
        .fence_vma (fence_vma),
        .flush_sel (flush_sel),
        .req       (req),
        .resp_id   (resp.id),   // frees the stage on its answer
        .held      (held)
    );

    page_walker u_walker (
        .clk         (clk),
        .rst         (rst),
        .fence_vma   (fence_vma),
        .flush_sel   (flush_sel),
        .satp_mode   (satp_mode),
        .root_ppn    (root_ppn),
        .held        (held),
        .mem_req_id  (mem_req_id),
        .mem_addr    (mem_addr),
        .mem_resp_id (mem_resp_id),
        .mem_rdata   (mem_rdata),
        .resp        (resp)
    );

endmodule

// ==== hw/page_walker.sv ====
/*
 * Page table walker.
 * Walks Sv39, Sv48 or Sv57 tables one entry at a time through a
 * word read port and answers with permissions and the page base.
 */
`include "ptw_defines.svh"

module page_walker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fence_vma,
    input  ptw_pkg::flush_sel_t         flush_sel,
    input  logic [`PTW_SATP_MODE_W-1:0] satp_mode,
    input  ptw_pkg::ppn_t               root_ppn,
    input  ptw_pkg::xlate_req_t         held,
    output ptw_pkg::req_id_t            mem_req_id,
    output ptw_pkg::paddr_t             mem_addr,
    input  ptw_pkg::req_id_t            mem_resp_id,
    input  ptw_pkg::pte_t               mem_rdata,
    output ptw_pkg::xlate_resp_t        resp
);
    import ptw_pkg::*;

    walk_state_t                            state;
    req_id_t                                cur_id;
    logic [`PTW_LEVELS-1:0][`PTW_VPN_W-1:0] vpn_q;
    ppn_t                                   ppn_q;
    logic [2:0]                             level_q;
    paddr_t                                 addr_q;
    pte_t                                   pte_q;
    perm_t                                  perm_q;
    logic                                   fault_q;
    logic                                   mode_ok;
    logic [2:0]                             start_level;
    logic                                   start;
    logic                                   abort;
    logic                                   mem_hit;
    logic                                   chk_leaf;
    logic                                   chk_fault;
    ppn_t                                   chk_ppn;

    always_comb begin
        mode_ok     = 1'b1;
        start_level = 3'd2;
        case (satp_mode)
            `PTW_MODE_SV39: start_level = 3'd2;
            `PTW_MODE_SV48: start_level = 3'd3;
            `PTW_MODE_SV57: start_level = 3'd4;
            default:        mode_ok     = 1'b0;  // bare or reserved
        endcase
    end

    assign start = (state == WALK_IDLE) && (held.id != `PTW_ID_NONE)
                   && !fence_vma && !id_cancelled(held.id, flush_sel);
    assign abort = (state != WALK_IDLE)
                   && (fence_vma || id_cancelled(cur_id, flush_sel));
    assign mem_hit = (state == WALK_WAIT) && (mem_resp_id == cur_id);

    pte_check u_check (
        .pte      (pte_q),
        .vpn      (vpn_q),
        .level    (level_q),
        .leaf     (chk_leaf),
        .fault    (chk_fault),
        .next_ppn (chk_ppn)
    );

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            state  <= WALK_IDLE;             // cancelled walks give no response
            cur_id <= `PTW_ID_NONE;
        end else begin
            case (state)
                WALK_IDLE: begin
                    if (start) begin
                        cur_id <= held.id;
                        state  <= mode_ok ? WALK_ADDR : WALK_DONE;
                    end
                end
                WALK_ADDR:  state <= WALK_WAIT;
                WALK_WAIT: begin
                    if (mem_hit) begin
                        state <= WALK_CHECK;
                    end
                end
                WALK_CHECK: state <= (chk_leaf || chk_fault) ? WALK_DONE : WALK_ADDR;
                WALK_DONE:  state <= WALK_IDLE;
                default:    state <= WALK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            WALK_IDLE: begin
                vpn_q   <= held.vaddr[`PTW_PAGE_SHIFT +: `PTW_LEVELS*`PTW_VPN_W];
                ppn_q   <= root_ppn;
                level_q <= start_level;
                fault_q <= !mode_ok;
            end
            WALK_ADDR: addr_q <= paddr_t'({ppn_q, vpn_q[level_q], 3'b000});
            WALK_WAIT: begin
                if (mem_hit) begin
                    pte_q <= mem_rdata;
                end
            end
            WALK_CHECK: begin
                ppn_q   <= chk_ppn;          // next table or page base
                perm_q  <= pte_q[`PTW_PERM_W-1:0];
                fault_q <= chk_fault;
                level_q <= level_q - 3'd1;
            end
            default: ;
        endcase
    end

    assign mem_req_id = (state == WALK_WAIT) ? cur_id : `PTW_ID_NONE;
    assign mem_addr   = addr_q;

    assign resp.id    = (state == WALK_DONE) ? cur_id : `PTW_ID_NONE;
    assign resp.perm  = fault_q ? '0 : perm_q;
    assign resp.paddr = fault_q ? '0 : paddr_t'({ppn_q, {`PTW_PAGE_SHIFT{1'b0}}});

endmodule

// ==== hw/pte_check.sv ====
/*
 * Page table entry check.
 * Decides leaf or pointer for a fetched entry, flags invalid and
 * misaligned entries and forms the next physical page number,
 * filling superpage fields from the virtual page number.
 */
`include "ptw_defines.svh"

module pte_check (
    input  ptw_pkg::pte_t                          pte,
    input  logic [`PTW_LEVELS-1:0][`PTW_VPN_W-1:0] vpn,
    input  logic [2:0]                             level,
    output logic                                   leaf,
    output logic                                   fault,
    output ptw_pkg::ppn_t                          next_ppn
);
    import ptw_pkg::*;

    ppn_t pte_ppn;
    logic valid;
    logic misaligned;       // low ppn field set on a superpage

    assign pte_ppn = pte[`PTW_PTE_PPN_LSB +: `PTW_PPN_W];
    assign valid   = pte[`PTW_PTE_V];
    assign leaf    = pte[`PTW_PTE_R] | pte[`PTW_PTE_X];

    always_comb begin
        misaligned = 1'b0;
        next_ppn   = pte_ppn;               // pointer to next table
        if (leaf) begin
            // fields below the current level come from the va
            for (int i = 0; i < `PTW_LEVELS - 1; i++) begin
                if (i < level) begin
                    if (pte_ppn[i*`PTW_VPN_W +: `PTW_VPN_W] != '0) begin
                        misaligned = 1'b1;
                    end
                    next_ppn[i*`PTW_VPN_W +: `PTW_VPN_W] = vpn[i];
                end
            end
        end
    end

    // a pointer at level 0 has nowhere left to go
    assign fault = !valid || (leaf && misaligned) || (!leaf && level == 3'd0);

endmodule

// ==== hw/request_hold.sv ====
/*
 * Translation request hold stage.
 * Captures one offered request and keeps it until the walker
 * answers its ID, or until a flush or fence.vma drops it.
 */
`include "ptw_defines.svh"

module request_hold (
    input  logic                clk,
    input  logic                rst,
    input  logic                fence_vma,
    input  ptw_pkg::flush_sel_t flush_sel,
    input  ptw_pkg::xlate_req_t req,
    input  ptw_pkg::req_id_t    resp_id,   // id answered this cycle
    output ptw_pkg::xlate_req_t held
);
    import ptw_pkg::*;

    req_id_t    id_q;
    vaddr_t     vaddr_q;
    logic       ready;
    xlate_req_t nxt;

    // free, or the held one is being answered right now
    assign ready = (id_q == `PTW_ID_NONE) || (id_q == resp_id);
    assign nxt   = ready ? req : held;

    always_ff @(posedge clk) begin
        if (rst || fence_vma || id_cancelled(nxt.id, flush_sel)) begin
            id_q <= `PTW_ID_NONE;
        end else begin
            id_q <= nxt.id;                 // zero when nothing offered
        end
    end

    always_ff @(posedge clk) begin
        vaddr_q <= nxt.vaddr;
    end

    assign held.id    = id_q;
    assign held.vaddr = vaddr_q;

endmodule

// ==== hw/walk_config.sv ====
/*
 * Walk configuration registers.
 * Keeps the SATP value that steers the page walker and decodes the
 * instruction and data flush levels into a mask and pattern pair.
 */
`include "ptw_defines.svh"

module walk_config (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              satp_we,     // one cycle write strobe
    input  ptw_pkg::pte_t                     satp_wdata,
    input  logic                              ic_flush,
    input  logic                              dc_flush,
    output logic [`PTW_SATP_MODE_W-1:0]       satp_mode,
    output ptw_pkg::ppn_t                     root_ppn,
    output ptw_pkg::flush_sel_t               flush_sel
);
    import ptw_pkg::*;

    pte_t satp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            satp_q <= '0;                   // bare mode
        end else if (satp_we) begin
            satp_q <= satp_wdata;
        end
    end

    assign satp_mode = satp_q[`PTW_PTE_W-1 -: `PTW_SATP_MODE_W];
    assign root_ppn  = satp_q[`PTW_PPN_W-1:0];

    // both levels together widen the match to every translation ID
    always_comb begin
        case ({dc_flush, ic_flush})
            2'b01: begin
                flush_sel.mask    = `PTW_FL_IC_MASK;
                flush_sel.pattern = `PTW_FL_IC_PAT;
            end
            2'b10: begin
                flush_sel.mask    = `PTW_FL_DC_MASK;
                flush_sel.pattern = `PTW_FL_DC_PAT;
            end
            2'b11: begin
                flush_sel.mask    = `PTW_FL_ALL_MASK;
                flush_sel.pattern = `PTW_FL_ALL_PAT;
            end
            default: begin
                flush_sel.mask    = '0;     // nothing cancelled
                flush_sel.pattern = '0;
            end
        endcase
    end

endmodule

// ==== hw/ptw_pkg.sv ====
/*
 * Page table walker types.
 * Vector typedefs, the walk state encoding, the request and
 * response bundles and the flush match rule.
 */
`include "ptw_defines.svh"

package ptw_pkg;

    typedef logic [`PTW_ID_W-1:0]   req_id_t;   // zero means no request
    typedef logic [`PTW_VA_W-1:0]   vaddr_t;
    typedef logic [`PTW_PA_W-1:0]   paddr_t;
    typedef logic [`PTW_PPN_W-1:0]  ppn_t;
    typedef logic [`PTW_PERM_W-1:0] perm_t;     // d a g u x w r v, msb first
    typedef logic [`PTW_PTE_W-1:0]  pte_t;

    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_ADDR,
        WALK_WAIT,
        WALK_CHECK,
        WALK_DONE
    } walk_state_t;

    typedef struct packed {
        req_id_t mask;      // don't care bits
        req_id_t pattern;
    } flush_sel_t;

    typedef struct packed {
        req_id_t id;
        vaddr_t  vaddr;
    } xlate_req_t;

    typedef struct packed {
        req_id_t id;
        perm_t   perm;
        paddr_t  paddr;
    } xlate_resp_t;

    // a live ID matching the pattern outside the mask is cancelled
    function automatic logic id_cancelled(input req_id_t id, input flush_sel_t sel);
        return (id != `PTW_ID_NONE) && ((id & ~sel.mask) == (sel.pattern & ~sel.mask));
    endfunction

endpackage

// ==== hw/ptw_defines.svh ====
/*
 * Page table walker parameters.
 * Widths, SATP mode codes, walk limits, entry bit positions,
 * flush select patterns and request ID ranges.
 */
`ifndef PTW_DEFINES_SVH
`define PTW_DEFINES_SVH

`define PTW_ID_W         8      // request ID
`define PTW_VA_W         64
`define PTW_PA_W         64
`define PTW_PPN_W        44
`define PTW_VPN_W        9      // one level of the vpn
`define PTW_PERM_W       8
`define PTW_PTE_W        64

`define PTW_MODE_SV39    4'd8
`define PTW_MODE_SV48    4'd9
`define PTW_MODE_SV57    4'd10
`define PTW_SATP_MODE_W  4      // mode sits in the top bits of satp

`define PTW_LEVELS       5      // five levels for sv57
`define PTW_PAGE_SHIFT   12
`define PTW_PTE_PPN_LSB  10
`define PTW_PTE_V        0
`define PTW_PTE_R        1
`define PTW_PTE_X        3

`define PTW_FL_IC_MASK   8'b0011_1111
`define PTW_FL_IC_PAT    8'b1000_0000
`define PTW_FL_DC_MASK   8'b0011_1111
`define PTW_FL_DC_PAT    8'b1100_0000
`define PTW_FL_ALL_MASK  8'b0111_1111
`define PTW_FL_ALL_PAT   8'b1000_0000

`define PTW_ID_NONE      8'h00
`define PTW_ID_IC_PFX    3'b100  // instruction side
`define PTW_ID_DC_PFX    3'b110  // data side

`endif
